/* Bender.yml */
package:
  name: execute

export_include_dirs:
  - common

sources:
  - common/exec_pkg.sv
  - hw/alu.sv
  - hw/branch_unit.sv
  - muldiv/mul_multicycle.sv
  - muldiv/div_multicycle.sv
  - hw/execute.sv
  - target: simulation
    include_dirs:
      - common
      - verification
    files:
      - verification/execute_tb.sv

/* common/exec_config.svh */
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// register stages from multiplier inputs to done, 1 or more
`define MUL_STAGES 3

// issue width, lane 1 holds the older instruction
`define EXEC_LANES 2

`endif

/* common/exec_pkg.sv */
package exec_pkg;

    // datapath widths
    typedef logic [31:0] word_t;
    typedef logic [63:0] dword_t;
    typedef logic [15:0] imm_t;

    // raw instruction word, shamt / offset / jump index are sliced from it
    typedef logic [31:0] instr_t;

    typedef enum logic [4:0] {
        NOP,
        ADD,
        ADDU,
        SUB,
        SUBU,
        AND,
        OR,
        XOR,
        NOR,
        SLT,
        SLTU,
        SLL,
        SRL,
        SRA,
        LUI,
        // handled by the shared multicycle units
        MULT,
        MULTU,
        DIV,
        DIVU
    } alu_op_t;

    // second alu operand source
    typedef enum logic {
        SRC_REG,
        SRC_IMM
    } src_b_t;

    // branch conditions, evaluated on lane 1 only
    typedef enum logic [2:0] {
        BEQ,
        BNE,
        BLEZ,
        BGTZ,
        BLTZ,
        BGEZ
    } branch_t;

endpackage

/* files.f */
+incdir+common
+incdir+verification
common/exec_pkg.sv
hw/alu.sv
hw/branch_unit.sv
muldiv/mul_multicycle.sv
muldiv/div_multicycle.sv
hw/execute.sv
verification/execute_tb.sv

/* hw/alu.sv */
`timescale 1ns/1ps

module alu (
    input  exec_pkg::word_t   a_i,
    input  exec_pkg::word_t   b_i,
    input  exec_pkg::alu_op_t op_i,
    output exec_pkg::word_t   result_o,
    output logic              overflow_o
);
    import exec_pkg::*;

    word_t      sum;
    word_t      diff;
    logic [4:0] sh;

    assign sum  = a_i + b_i;
    assign diff = a_i - b_i;
    // shift amount is either shamt or rs, low five bits
    assign sh   = a_i[4:0];

    always_comb begin
        result_o   = '0;
        overflow_o = 1'b0;
        unique case (op_i)
            ADD: begin
                result_o   = sum;
                // same operand signs, result sign flipped
                overflow_o = (a_i[31] == b_i[31]) && (sum[31] != a_i[31]);
            end
            ADDU: result_o = sum;
            SUB: begin
                result_o   = diff;
                overflow_o = (a_i[31] != b_i[31]) && (diff[31] != a_i[31]);
            end
            SUBU: result_o = diff;
            AND:  result_o = a_i & b_i;
            OR:   result_o = a_i | b_i;
            XOR:  result_o = a_i ^ b_i;
            NOR:  result_o = ~(a_i | b_i);
            SLT:  result_o = {31'b0, $signed(a_i) < $signed(b_i)};
            SLTU: result_o = {31'b0, a_i < b_i};
            // shifts operate on rt, the b operand
            SLL:  result_o = b_i << sh;
            SRL:  result_o = b_i >> sh;
            SRA:  result_o = word_t'($signed(b_i) >>> sh);
            LUI:  result_o = {b_i[15:0], 16'b0};
            // nop and mul/div produce nothing here
            default: result_o = '0;
        endcase
    end

endmodule

/* hw/branch_unit.sv */
`timescale 1ns/1ps

module branch_unit (
    input  exec_pkg::word_t   rs_i,
    input  exec_pkg::word_t   rt_i,
    input  exec_pkg::word_t   pc_i,
    input  exec_pkg::instr_t  instr_i,
    input  exec_pkg::branch_t branch_type_i,
    input  logic              is_branch_i,
    input  logic              is_jump_i,
    input  logic              is_jr_i,
    output exec_pkg::word_t   target_o,
    output logic              taken_o
);
    import exec_pkg::*;

    word_t slot_pc;
    word_t offset;
    logic  cond;

    // pc of the delay slot
    assign slot_pc = pc_i + 32'd4;
    assign offset  = {{14{instr_i[15]}}, instr_i[15:0], 2'b00};

    always_comb begin
        unique case (branch_type_i)
            BEQ:     cond = (rs_i == rt_i);
            BNE:     cond = (rs_i != rt_i);
            BLEZ:    cond = rs_i[31] || (rs_i == '0);
            BGTZ:    cond = !rs_i[31] && (rs_i != '0);
            BLTZ:    cond = rs_i[31];
            BGEZ:    cond = !rs_i[31];
            default: cond = 1'b0;
        endcase
    end

    always_comb begin
        target_o = '0;
        if (is_branch_i) begin
            target_o = slot_pc + offset;
        end else if (is_jr_i) begin
            target_o = rs_i;
        end else if (is_jump_i) begin
            // region of the slot, index from the instruction
            target_o = {slot_pc[31:28], instr_i[25:0], 2'b00};
        end
    end

    // jr redirects via target only, no taken flag
    assign taken_o = is_jump_i || (is_branch_i && cond);

endmodule

/* hw/execute.sv */
`timescale 1ns/1ps
`include "exec_config.svh"

module execute (
    input  logic                                    clk,
    input  logic                                    reset_i,
    input  logic             [`EXEC_LANES-1:0]      valid_i,
    input  exec_pkg::alu_op_t [`EXEC_LANES-1:0]     op_i,
    input  exec_pkg::word_t  [`EXEC_LANES-1:0]      rs_i,
    input  exec_pkg::word_t  [`EXEC_LANES-1:0]      rt_i,
    input  exec_pkg::imm_t   [`EXEC_LANES-1:0]      imm_i,
    input  exec_pkg::instr_t [`EXEC_LANES-1:0]      instr_i,
    input  exec_pkg::word_t  [`EXEC_LANES-1:0]      pc_i,
    input  exec_pkg::src_b_t [`EXEC_LANES-1:0]      src_b_i,
    input  logic             [`EXEC_LANES-1:0]      zero_ext_i,
    input  logic             [`EXEC_LANES-1:0]      shamt_sel_i,
    input  logic                                    is_branch_i,
    input  exec_pkg::branch_t                       branch_type_i,
    input  logic                                    is_jump_i,
    input  logic                                    is_jr_i,
    input  logic                                    is_link_i,
    output logic             [`EXEC_LANES-1:0]      valid_o,
    output exec_pkg::word_t  [`EXEC_LANES-1:0]      alu_out_o,
    output logic             [`EXEC_LANES-1:0]      overflow_o,
    output exec_pkg::word_t                         target_o,
    output logic                                    branch_taken_o,
    output exec_pkg::dword_t [`EXEC_LANES-1:0]      hilo_o,
    output logic                                    stall_o
);
    import exec_pkg::*;

    function automatic logic is_mul(alu_op_t op);
        return (op == MULT) || (op == MULTU);
    endfunction

    function automatic logic is_div(alu_op_t op);
        return (op == DIV) || (op == DIVU);
    endfunction

    word_t [`EXEC_LANES-1:0] op_a;
    word_t [`EXEC_LANES-1:0] op_b;
    word_t [`EXEC_LANES-1:0] ext_imm;
    word_t [`EXEC_LANES-1:0] alu_res;
    logic  [`EXEC_LANES-1:0] alu_ovf;
    logic  [`EXEC_LANES-1:0] lane_ovf;

    logic    md_lane;
    alu_op_t md_op;
    word_t   md_a;
    word_t   md_b;
    logic    neg_a;
    logic    neg_b;
    word_t   mag_a;
    word_t   mag_b;
    logic    mul_start;
    logic    mul_done;
    logic    div_start;
    logic    div_done;
    dword_t  mul_res;
    dword_t  div_res;
    dword_t  mul_fixed;
    dword_t  div_fixed;
    dword_t  md_hilo;

    for (genvar l = 0; l < `EXEC_LANES; l++) begin : g_lane
        assign ext_imm[l] = zero_ext_i[l] ? {16'b0, imm_i[l]} : {{16{imm_i[l][15]}}, imm_i[l]};
        // shamt field bits 10..6 replaces rs for immediate shifts
        assign op_a[l]    = shamt_sel_i[l] ? {27'b0, instr_i[l][10:6]} : rs_i[l];

        always_comb begin
            unique case (src_b_i[l])
                SRC_IMM: op_b[l] = ext_imm[l];
                default: op_b[l] = rt_i[l];
            endcase
        end

        alu i_alu (
            .a_i       (op_a[l]),
            .b_i       (op_b[l]),
            .op_i      (op_i[l]),
            .result_o  (alu_res[l]),
            .overflow_o(alu_ovf[l])
        );

        assign lane_ovf[l] = valid_i[l] && alu_ovf[l];
    end

    // lane 1 is older, its overflow kills the slot instruction
    assign valid_o[1]    = valid_i[1];
    assign valid_o[0]    = valid_i[0] && !lane_ovf[1];
    assign overflow_o[1] = lane_ovf[1];
    assign overflow_o[0] = lane_ovf[0] && !lane_ovf[1];

    assign alu_out_o[1] = is_link_i ? pc_i[1] + 32'd8 : alu_res[1];
    assign alu_out_o[0] = alu_res[0];

    branch_unit i_branch_unit (
        .rs_i         (rs_i[1]),
        .rt_i         (rt_i[1]),
        .pc_i         (pc_i[1]),
        .instr_i      (instr_i[1]),
        .branch_type_i(branch_type_i),
        .is_branch_i  (is_branch_i),
        .is_jump_i    (is_jump_i),
        .is_jr_i      (is_jr_i),
        .target_o     (target_o),
        .taken_o      (branch_taken_o)
    );

    // lane 1 wins the shared mul/div units
    assign md_lane = is_mul(op_i[1]) || is_div(op_i[1]);
    assign md_op   = op_i[md_lane];
    assign md_a    = rs_i[md_lane];
    assign md_b    = rt_i[md_lane];

    // signed ops run on magnitudes
    assign neg_a = (md_op == MULT || md_op == DIV) && md_a[31];
    assign neg_b = (md_op == MULT || md_op == DIV) && md_b[31];
    assign mag_a = neg_a ? -md_a : md_a;
    assign mag_b = neg_b ? -md_b : md_b;

    assign mul_start = is_mul(md_op);
    assign div_start = is_div(md_op);

    mul_multicycle i_mul (
        .clk     (clk),
        .reset_i (reset_i),
        .start_i (mul_start),
        .a_i     (mag_a),
        .b_i     (mag_b),
        .done_o  (mul_done),
        .result_o(mul_res)
    );

    div_multicycle i_div (
        .clk     (clk),
        .reset_i (reset_i),
        .start_i (div_start),
        .a_i     (mag_a),
        .b_i     (mag_b),
        .done_o  (div_done),
        .result_o(div_res)
    );

    assign mul_fixed = (neg_a ^ neg_b) ? -mul_res : mul_res;
    // remainder follows the dividend sign, quotient the sign product
    assign div_fixed = {neg_a ? -div_res[63:32] : div_res[63:32],
                        (neg_a ^ neg_b) ? -div_res[31:0] : div_res[31:0]};

    always_comb begin
        md_hilo = '0;
        if (mul_start && mul_done) begin
            md_hilo = mul_fixed;
        end else if (div_start && div_done) begin
            md_hilo = div_fixed;
        end
    end

    always_comb begin
        hilo_o          = '0;
        hilo_o[md_lane] = md_hilo;
    end

    assign stall_o = (mul_start && !mul_done) || (div_start && !div_done);

endmodule

/* muldiv/div_multicycle.sv */
`timescale 1ns/1ps

module div_multicycle (
    input  logic             clk,
    input  logic             reset_i,
    input  logic             start_i,
    input  exec_pkg::word_t  a_i,
    input  exec_pkg::word_t  b_i,
    output logic             done_o,
    output exec_pkg::dword_t result_o
);
    import exec_pkg::*;

    typedef enum logic {
        IDLE,
        RUN
    } div_state_t;

    div_state_t  state_q;
    logic [5:0]  count_q;
    word_t       rem_q;
    word_t       quo_q;
    word_t       dvs_q;
    logic [32:0] partial;
    logic [32:0] trial;

    // shift next dividend bit into the remainder and try a subtract
    assign partial = {rem_q, quo_q[31]};
    assign trial   = partial - {1'b0, dvs_q};

    // 32 steps done, result held for one cycle
    assign done_o   = (state_q == RUN) && (count_q == 6'd32);
    assign result_o = {rem_q, quo_q};

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= IDLE;
            count_q <= '0;
        end else begin
            unique case (state_q)
                IDLE: begin
                    if (start_i) begin
                        state_q <= RUN;
                        count_q <= '0;
                    end
                end
                RUN: begin
                    if (done_o) begin
                        state_q <= IDLE;
                    end else begin
                        count_q <= count_q + 6'd1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE && start_i) begin
            rem_q <= '0;
            quo_q <= a_i;
            dvs_q <= b_i;
        end else if (state_q == RUN && !done_o) begin
            // no borrow means the divisor fits, keep the difference
            if (!trial[32]) begin
                rem_q <= trial[31:0];
                quo_q <= {quo_q[30:0], 1'b1};
            end else begin
                rem_q <= partial[31:0];
                quo_q <= {quo_q[30:0], 1'b0};
            end
        end
    end

endmodule

/* muldiv/mul_multicycle.sv */
`timescale 1ns/1ps
`include "exec_config.svh"

module mul_multicycle (
    input  logic             clk,
    input  logic             reset_i,
    input  logic             start_i,
    input  exec_pkg::word_t  a_i,
    input  exec_pkg::word_t  b_i,
    output logic             done_o,
    output exec_pkg::dword_t result_o
);
    import exec_pkg::*;

    localparam int STAGES = `MUL_STAGES;

    dword_t            prod_q [STAGES];
    logic [STAGES-1:0] vld_q;
    logic              busy_q;
    logic              launch;

    // only a fresh start from idle enters the pipe
    assign launch = start_i && !busy_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            vld_q  <= '0;
            busy_q <= 1'b0;
        end else begin
            vld_q[0] <= launch;
            for (int k = 1; k < STAGES; k++) begin
                vld_q[k] <= vld_q[k-1];
            end
            if (launch) begin
                busy_q <= 1'b1;
            end else if (done_o) begin
                busy_q <= 1'b0;
            end
        end
    end

    // first stage captures the full product of the inputs
    always_ff @(posedge clk) begin
        prod_q[0] <= dword_t'(a_i) * dword_t'(b_i);
        for (int k = 1; k < STAGES; k++) begin
            prod_q[k] <= prod_q[k-1];
        end
    end

    assign done_o   = vld_q[STAGES-1];
    assign result_o = prod_q[STAGES-1];

endmodule

/* verification/execute_model.svh */
`ifndef EXECUTE_MODEL_SVH
`define EXECUTE_MODEL_SVH

// reference behaviour of the execute stage, written from the instruction rules

function automatic word_t operand_a(logic shamt_sel, word_t rs, instr_t instr);
    return shamt_sel ? word_t'(instr[10:6]) : rs;
endfunction

function automatic word_t operand_b(src_b_t src, logic zext, word_t rt, imm_t imm);
    if (src == SRC_REG)
        return rt;
    return zext ? word_t'(imm) : word_t'($signed(imm));
endfunction

function automatic word_t alu_result(alu_op_t op, word_t a, word_t b);
    case (op)
        ADD, ADDU: return a + b;
        SUB, SUBU: return a - b;
        AND:       return a & b;
        OR:        return a | b;
        XOR:       return a ^ b;
        NOR:       return ~(a | b);
        SLT:       return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        SLTU:      return (a < b) ? 32'd1 : 32'd0;
        SLL:       return b << a[4:0];
        SRL:       return b >> a[4:0];
        SRA:       return word_t'($signed(b) >>> a[4:0]);
        LUI:       return {b[15:0], 16'h0000};
        default:   return '0;
    endcase
endfunction

// true result out of the 32-bit signed range
function automatic logic signed_overflow(alu_op_t op, word_t a, word_t b);
    longint s;
    if (op == ADD)
        s = longint'($signed(a)) + longint'($signed(b));
    else if (op == SUB)
        s = longint'($signed(a)) - longint'($signed(b));
    else
        return 1'b0;
    return (s > 64'sd2147483647) || (s < -64'sd2147483648);
endfunction

function automatic logic branch_holds(branch_t t, word_t rs, word_t rt);
    case (t)
        BEQ:     return rs == rt;
        BNE:     return rs != rt;
        BLEZ:    return $signed(rs) <= 0;
        BGTZ:    return $signed(rs) > 0;
        BLTZ:    return $signed(rs) < 0;
        BGEZ:    return $signed(rs) >= 0;
        default: return 1'b0;
    endcase
endfunction

function automatic word_t redirect_target(logic br, logic jr, logic jmp, word_t rs,
                                          word_t pc, instr_t instr);
    word_t nxt;
    nxt = pc + 32'd4;
    if (br)
        return nxt + (word_t'($signed(instr[15:0])) << 2);
    if (jr)
        return rs;
    if (jmp)
        return {nxt[31:28], instr[25:0], 2'b00};
    return '0;
endfunction

// hi is the remainder, lo the quotient; a zero divisor leaves hi at the dividend
function automatic dword_t hilo_result(alu_op_t op, word_t a, word_t b);
    longint sa;
    longint sb;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    case (op)
        MULT:  return dword_t'(sa * sb);
        MULTU: return {32'h0, a} * {32'h0, b};
        DIV: begin
            if (b == '0)
                return {a, a[31] ? 32'h0000_0001 : 32'hffff_ffff};
            return {word_t'(sa % sb), word_t'(sa / sb)};
        end
        DIVU:  return (b == '0) ? {a, 32'hffff_ffff} : {a % b, a / b};
        default: return '0;
    endcase
endfunction

`endif

/* verification/execute_tb.sv */
`timescale 1ns/1ps
`include "exec_config.svh"

module execute_tb;
    import exec_pkg::*;
    `include "execute_model.svh"

    localparam int N_ALU = 400;
    localparam int N_OVF = 60;
    localparam int N_BR  = 300;
    localparam int N_MD  = 150;
    localparam int LIMIT = N_ALU + N_OVF + N_BR + N_MD * (33 + `MUL_STAGES + 2) + 16 + 200;

    logic clk = 1'b0;
    logic reset_i;
    logic [1:0] valid, zext, shamt, valid_o, overflow_o;
    alu_op_t [1:0] op;
    word_t [1:0] rs, rt, pc, alu_out_o;
    imm_t [1:0] imm;
    instr_t [1:0] instr;
    src_b_t [1:0] src_b;
    logic is_branch, is_jump, is_jr, is_link, branch_taken_o, stall_o;
    branch_t btype;
    word_t target_o;
    dword_t [1:0] hilo_o;
    logic [31:0] lfsr = 32'hfeeb_d2a1;
    int errors = 0;
    int checks = 0;
    int cycles = 0;

    execute i_dut (
        .clk(clk), .reset_i(reset_i), .valid_i(valid), .op_i(op), .rs_i(rs), .rt_i(rt),
        .imm_i(imm), .instr_i(instr), .pc_i(pc), .src_b_i(src_b), .zero_ext_i(zext),
        .shamt_sel_i(shamt), .is_branch_i(is_branch), .branch_type_i(btype),
        .is_jump_i(is_jump), .is_jr_i(is_jr), .is_link_i(is_link), .valid_o(valid_o),
        .alu_out_o(alu_out_o), .overflow_o(overflow_o), .target_o(target_o),
        .branch_taken_o(branch_taken_o), .hilo_o(hilo_o), .stall_o(stall_o)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("timeout after %0d cycles, stall_o never cleared", LIMIT);
            $display("Some tests failed");
            $finish;
        end
    end

    // fibonacci lfsr with taps 32 22 2 1, stepped once per bit
    function automatic logic [31:0] next_bits(int n);
        logic [31:0] v;
        logic fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic check_word(string name, word_t exp, word_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERR %0t %s exp=%h act=%h", $time, name, exp, act);
        end
    endtask

    task automatic compare_dword(string name, dword_t exp, dword_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERR %0t %s exp=%h act=%h", $time, name, exp, act);
        end
    endtask

    task automatic expect_bit(string name, logic exp, logic act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERR %0t %s exp=%b act=%b", $time, name, exp, act);
        end
    endtask

    task automatic drive_idle();
        valid = '0;
        op[1] = NOP;
        op[0] = NOP;
        rs = '0;
        rt = '0;
        imm = '0;
        instr = '0;
        pc = '0;
        src_b[1] = SRC_REG;
        src_b[0] = SRC_REG;
        zext = '0;
        shamt = '0;
        {is_branch, is_jump, is_jr, is_link} = '0;
        btype = BEQ;
    endtask

    task automatic random_lane(int l);
        op[l] = alu_op_t'(next_bits(4) % 15);
        rs[l] = next_bits(32);
        rt[l] = next_bits(32);
        imm[l] = imm_t'(next_bits(16));
        instr[l] = next_bits(32);
        pc[l] = next_bits(30) << 2;
        src_b[l] = src_b_t'(next_bits(1));
        zext[l] = (next_bits(1) != 0);
        shamt[l] = (next_bits(1) != 0);
        valid[l] = (next_bits(3) != 0);
    endtask

    // combinational outputs of both lanes and the lane 1 control flow
    task automatic verify_lanes();
        word_t res [2];
        logic ovf [2];
        for (int l = 0; l < 2; l++) begin
            res[l] = alu_result(op[l], operand_a(shamt[l], rs[l], instr[l]),
                                operand_b(src_b[l], zext[l], rt[l], imm[l]));
            ovf[l] = valid[l] && signed_overflow(op[l], operand_a(shamt[l], rs[l], instr[l]),
                                                 operand_b(src_b[l], zext[l], rt[l], imm[l]));
        end
        if (is_link)
            res[1] = pc[1] + 32'd8;
        check_word("alu_out_o[1]", res[1], alu_out_o[1]);
        check_word("alu_out_o[0]", res[0], alu_out_o[0]);
        expect_bit("overflow_o[1]", ovf[1], overflow_o[1]);
        expect_bit("overflow_o[0]", ovf[0] && !ovf[1], overflow_o[0]);
        expect_bit("valid_o[1]", valid[1], valid_o[1]);
        expect_bit("valid_o[0]", valid[0] && !ovf[1], valid_o[0]);
        check_word("target_o", redirect_target(is_branch, is_jr, is_jump, rs[1], pc[1],
                   instr[1]), target_o);
        expect_bit("branch_taken_o", is_jump || (is_branch && branch_holds(btype, rs[1],
                   rt[1])), branch_taken_o);
    endtask

    // hold inputs through the stall, then check the issuing lane
    task automatic run_muldiv();
        int lane;
        int latency;
        int waited;
        lane = (op[1] >= MULT) ? 1 : 0;
        // divider takes a load cycle and 32 steps
        latency = (op[lane] >= DIV) ? 33 : `MUL_STAGES;
        waited = 0;
        #5;
        while (stall_o) begin
            verify_lanes();
            waited++;
            @(negedge clk);
            #5;
        end
        verify_lanes();
        checks++;
        if (waited != latency) begin
            errors++;
            $display("stall_o stayed high for %0d cycles instead of %0d at %0t",
                     waited, latency, $time);
        end
        compare_dword($sformatf("hilo_o[%0d]", lane), hilo_result(op[lane], rs[lane],
                      rt[lane]), hilo_o[lane]);
        compare_dword($sformatf("hilo_o[%0d]", 1 - lane), '0, hilo_o[1 - lane]);
    endtask

    initial begin
        int kind;
        int l;
        drive_idle();
        reset_i = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;

        for (int n = 0; n < N_ALU; n++) begin
            @(negedge clk);
            drive_idle();
            random_lane(1);
            random_lane(0);
            #5;
            verify_lanes();
            expect_bit("stall_o", 1'b0, stall_o);
        end

        // forced signed overflow on lane 1, lane 0 or both
        for (int n = 0; n < N_OVF; n++) begin
            @(negedge clk);
            drive_idle();
            valid = 2'b11;
            for (l = 0; l < 2; l++) begin
                if (((n % 3) + 1) & (1 << l)) begin
                    op[l] = next_bits(1) ? ADD : SUB;
                    rs[l] = 32'h4000_0000 | next_bits(30);
                    rt[l] = (op[l] == ADD) ? (32'h4000_0000 | next_bits(30))
                                           : (32'h8000_0000 | next_bits(30));
                end else begin
                    op[l] = ADDU;
                    rs[l] = next_bits(32);
                    rt[l] = next_bits(32);
                end
            end
            #5;
            verify_lanes();
            expect_bit("stall_o", 1'b0, stall_o);
        end

        for (int n = 0; n < N_BR; n++) begin
            @(negedge clk);
            drive_idle();
            random_lane(1);
            random_lane(0);
            kind = next_bits(2);
            is_branch = (kind == 0);
            is_jump = (kind == 1);
            is_jr = (kind == 2);
            is_link = (next_bits(1) != 0);
            btype = branch_t'(next_bits(3) % 6);
            if (next_bits(1))
                rt[1] = rs[1];
            #5;
            verify_lanes();
            expect_bit("stall_o", 1'b0, stall_o);
        end

        // mul/div on one lane or both next to alu ops
        for (int n = 0; n < N_MD; n++) begin
            @(negedge clk);
            drive_idle();
            random_lane(1);
            random_lane(0);
            kind = (n < N_MD / 2) ? 1 + (next_bits(2) % 3) : 3;
            for (l = 0; l < 2; l++) begin
                if (kind & (1 << (1 - l))) begin
                    op[l] = alu_op_t'(MULT + (next_bits(2) % 4));
                    if (next_bits(3) == 0)
                        rt[l] = '0;
                end
            end
            run_muldiv();
        end

        @(negedge clk);
        drive_idle();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule
